/* hw/fe_settings.svh */
`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// instructions fetched, decoded and issued together.
`define FE_LANES 2

// architectural register index, 16 registers.
`define FE_AREG_W 4

// physical tag, 32 tags.
`define FE_TAG_W 5

// instruction store size in words and its address width.
`define FE_IMEM_DEPTH 64
`define FE_PC_W 6

// immediate field of an instruction word.
`define FE_IMM_W 16

`endif

/* hw/fe_pkg.sv */
package fe_pkg;

  // opcode field, bits 31..28 of an instruction word.
  // codes not listed here decode as nop.
  typedef enum logic [3:0] {
    OP_NOP   = 4'h0,
    OP_ADD   = 4'h1,
    OP_SUB   = 4'h2,
    OP_AND   = 4'h3,
    OP_OR    = 4'h4,
    OP_LOADI = 4'h5
  } fe_op_e;

  // loader FSM.
  typedef enum logic [1:0] {
    LD_IDLE,
    LD_RUN,
    LD_DONE
  } fe_load_state_e;

  // APB register map, byte addresses.
  // the instruction store starts at REG_IMEM_BASE, one word every 4 bytes.
  typedef enum logic [11:0] {
    REG_CTRL      = 12'h000,
    REG_LEN       = 12'h004,
    REG_STATUS    = 12'h008,
    REG_IMEM_BASE = 12'h100
  } fe_reg_addr_e;

endpackage

/* hw/fe_apb_regs.sv */
`timescale 1ns/1ps
`include "fe_settings.svh"

module fe_apb_regs (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [11:0]         paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  output logic                start,
  output logic [`FE_PC_W:0]   len,
  input  logic [`FE_PC_W-1:0] rd_addr [`FE_LANES],
  output logic [31:0]         rd_word [`FE_LANES],
  input  logic                busy,
  input  logic                done
);
  import fe_pkg::*;

  logic [31:0]         imem [`FE_IMEM_DEPTH];
  logic                access;
  logic                wr_en;
  logic                hit_ctrl;
  logic                hit_len;
  logic                hit_status;
  logic                hit_imem;
  logic                unmapped;
  logic [`FE_PC_W-1:0] imem_idx;

  // no wait states, every access phase completes.
  assign pready = 1'b1;

  assign access     = psel && penable;
  assign wr_en      = access && pwrite;
  assign hit_ctrl   = (paddr == REG_CTRL);
  assign hit_len    = (paddr == REG_LEN);
  assign hit_status = (paddr == REG_STATUS);
  // word aligned addresses inside the store window.
  assign hit_imem   = ((paddr & 12'hf03) == REG_IMEM_BASE);
  assign unmapped   = !(hit_ctrl || hit_len || hit_status || hit_imem);
  assign imem_idx   = paddr[2 +: `FE_PC_W];

  assign pslverr = access && (unmapped ||
                              (pwrite && hit_status) ||
                              (pwrite && hit_imem && busy));

  // start is a one cycle pulse, the CTRL bit clears itself.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start <= 1'b0;
      len   <= '0;
    end else begin
      start <= wr_en && hit_ctrl && pwdata[0];
      if (wr_en && hit_len) begin
        len <= pwdata[`FE_PC_W:0];
      end
    end
  end

  // program writes are refused while the loader runs.
  always_ff @(posedge clk) begin
    if (wr_en && hit_imem && !busy) begin
      imem[imem_idx] <= pwdata;
    end
  end

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (hit_ctrl) begin
        prdata = {31'b0, start};
      end else if (hit_len) begin
        prdata = 32'(len);
      end else if (hit_status) begin
        prdata = {30'b0, done, busy};
      end else if (hit_imem) begin
        prdata = imem[imem_idx];
      end
    end
  end

  // loader read ports, one word per lane.
  always_comb begin
    for (int l = 0; l < `FE_LANES; l++) begin
      rd_word[l] = imem[rd_addr[l]];
    end
  end

  // an access phase always follows a setup phase.
  a_apb_setup: assert property (@(posedge clk) disable iff (!arst_n)
    penable |-> psel && $past(psel && !penable));

endmodule

/* hw/fe_loader.sv */
`timescale 1ns/1ps
`include "fe_settings.svh"

module fe_loader (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  logic [`FE_PC_W:0]    len,
  input  logic                 stall,
  input  logic                 issued_last,
  output logic [`FE_PC_W-1:0]  rd_addr [`FE_LANES],
  input  logic [31:0]          rd_word [`FE_LANES],
  output logic [`FE_LANES-1:0] fetch_valid,
  output logic [31:0]          fetch_word [`FE_LANES],
  output logic                 busy,
  output logic                 done
);
  import fe_pkg::*;

  localparam logic [`FE_PC_W:0] pc_step = `FE_LANES;

  fe_load_state_e   state;
  // one bit wider than the store address so the pc can reach len = 64.
  logic [`FE_PC_W:0] pc;
  logic [`FE_PC_W:0] lane_pc [`FE_LANES];

  // a lane past the end of the program stays invalid.
  always_comb begin
    for (int l = 0; l < `FE_LANES; l++) begin
      lane_pc[l]     = pc + (`FE_PC_W+1)'(l);
      rd_addr[l]     = lane_pc[l][`FE_PC_W-1:0];
      fetch_valid[l] = (state == LD_RUN) && (lane_pc[l] < len);
      fetch_word[l]  = rd_word[l];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= LD_IDLE;
      pc    <= '0;
    end else begin
      case (state)
        LD_IDLE, LD_DONE: begin
          if (start) begin
            state <= LD_RUN;
            pc    <= '0;
          end
        end
        LD_RUN: begin
          if (fetch_valid[0] && !stall) begin
            pc <= pc + pc_step;
          end
          // everything fetched and the final pair has left the issue port.
          if (!fetch_valid[0] && issued_last) begin
            state <= LD_DONE;
          end
        end
        default: state <= LD_IDLE;
      endcase
    end
  end

  assign busy = (state == LD_RUN);
  assign done = (state == LD_DONE);

  a_lane_order: assert property (@(posedge clk) disable iff (!arst_n)
    fetch_valid[1] |-> fetch_valid[0]);

endmodule

/* hw/fe_decoder.sv */
`timescale 1ns/1ps
`include "fe_settings.svh"

module fe_decoder (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  stall,
  input  logic                  fetch_valid,
  input  logic [31:0]           fetch_word,
  output logic                  dec_valid,
  output fe_pkg::fe_op_e        op,
  output logic [`FE_AREG_W-1:0] rd,
  output logic [`FE_AREG_W-1:0] rs1,
  output logic [`FE_AREG_W-1:0] rs2,
  output logic [`FE_IMM_W-1:0]  imm,
  output logic                  dst_valid
);
  import fe_pkg::*;

  fe_op_e                op_d;
  logic                  writes_rd;
  logic [`FE_AREG_W-1:0] rs1_d;
  logic [`FE_AREG_W-1:0] rs2_d;

  always_comb begin
    case (fetch_word[31:28])
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_LOADI: begin
        op_d = fe_op_e'(fetch_word[31:28]);
      end
      default: op_d = OP_NOP;
    endcase

    // every operation except nop writes rd.
    writes_rd = (op_d != OP_NOP);

    rs1_d = fetch_word[20 +: `FE_AREG_W];
    rs2_d = fetch_word[16 +: `FE_AREG_W];
    // loadi and nop read no registers.
    if (op_d == OP_LOADI || op_d == OP_NOP) begin
      rs1_d = '0;
      rs2_d = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
      dst_valid <= 1'b0;
    end else if (!stall) begin
      dec_valid <= fetch_valid;
      dst_valid <= fetch_valid && writes_rd;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      op  <= op_d;
      rd  <= fetch_word[24 +: `FE_AREG_W];
      rs1 <= rs1_d;
      rs2 <= rs2_d;
      imm <= fetch_word[`FE_IMM_W-1:0];
    end
  end

endmodule

/* hw/fe_renamer.sv */
`timescale 1ns/1ps
`include "fe_settings.svh"

module fe_renamer (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`FE_LANES-1:0]  dec_valid,
  input  fe_pkg::fe_op_e        op [`FE_LANES],
  input  logic [`FE_AREG_W-1:0] rd [`FE_LANES],
  input  logic [`FE_AREG_W-1:0] rs1 [`FE_LANES],
  input  logic [`FE_AREG_W-1:0] rs2 [`FE_LANES],
  input  logic [`FE_IMM_W-1:0]  imm [`FE_LANES],
  input  logic [`FE_LANES-1:0]  dst_valid,
  output logic                  stall,
  output logic [`FE_LANES-1:0]  issue_valid,
  output fe_pkg::fe_op_e        issue_op [`FE_LANES],
  output logic [`FE_LANES-1:0]  issue_dst_valid,
  output logic [`FE_TAG_W-1:0]  issue_dst_tag [`FE_LANES],
  output logic [`FE_TAG_W-1:0]  issue_src1_tag [`FE_LANES],
  output logic [`FE_TAG_W-1:0]  issue_src2_tag [`FE_LANES],
  output logic [`FE_IMM_W-1:0]  issue_imm [`FE_LANES],
  output logic                  issued_last,
  input  logic                  issue_ready
);
  import fe_pkg::*;

  localparam int areg_num = 1 << `FE_AREG_W;

  // rename table, architectural register to physical tag.
  logic [`FE_TAG_W-1:0] rat [areg_num];
  logic [`FE_TAG_W-1:0] next_tag;
  logic [`FE_TAG_W-1:0] tag_run;
  logic [`FE_TAG_W-1:0] new_tag [`FE_LANES];
  logic [`FE_TAG_W-1:0] src1_tag [`FE_LANES];
  logic [`FE_TAG_W-1:0] src2_tag [`FE_LANES];
  logic [`FE_LANES-1:0] allocs;
  logic                 transfer;

  assign transfer = |issue_valid && issue_ready;
  assign stall    = |issue_valid && !issue_ready;
  // the decoder stage runs empty only behind the final pair of a program.
  assign issued_last = transfer && !dec_valid[0];

  // consecutive tags, lane 0 first.
  always_comb begin
    tag_run = next_tag;
    for (int l = 0; l < `FE_LANES; l++) begin
      allocs[l]  = dec_valid[l] && dst_valid[l];
      new_tag[l] = tag_run;
      if (allocs[l]) begin
        tag_run = tag_run + 1'b1;
      end
    end
  end

  // older lanes of the same pair override the table.
  always_comb begin
    for (int l = 0; l < `FE_LANES; l++) begin
      src1_tag[l] = rat[rs1[l]];
      src2_tag[l] = rat[rs2[l]];
      for (int k = 0; k < l; k++) begin
        if (allocs[k] && rd[k] == rs1[l]) begin
          src1_tag[l] = new_tag[k];
        end
        if (allocs[k] && rd[k] == rs2[l]) begin
          src2_tag[l] = new_tag[k];
        end
      end
    end
  end

  // later lanes write last and win on a shared rd.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < areg_num; r++) begin
        rat[r] <= `FE_TAG_W'(r);
      end
      next_tag <= `FE_TAG_W'(areg_num);
    end else if (!stall) begin
      for (int l = 0; l < `FE_LANES; l++) begin
        if (allocs[l]) begin
          rat[rd[l]] <= new_tag[l];
        end
      end
      next_tag <= tag_run;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_valid     <= '0;
      issue_dst_valid <= '0;
    end else if (!stall) begin
      issue_valid     <= dec_valid;
      issue_dst_valid <= allocs;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      for (int l = 0; l < `FE_LANES; l++) begin
        issue_op[l]       <= op[l];
        issue_dst_tag[l]  <= new_tag[l];
        issue_src1_tag[l] <= src1_tag[l];
        issue_src2_tag[l] <= src2_tag[l];
        issue_imm[l]      <= imm[l];
      end
    end
  end

  // a waiting pair keeps its payload.
  generate
    for (genvar l = 0; l < `FE_LANES; l++) begin : gen_hold
      a_issue_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (issue_valid[l] && !issue_ready) |=>
          issue_valid[l] && $stable(issue_op[l]) && $stable(issue_dst_tag[l]) &&
          $stable(issue_src1_tag[l]) && $stable(issue_src2_tag[l]) &&
          $stable(issue_imm[l]));
    end
  endgenerate

endmodule

/* hw/fe_top.sv */
`timescale 1ns/1ps
`include "fe_settings.svh"

module fe_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [11:0]          paddr,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pready,
  output logic                 pslverr,
  output logic [`FE_LANES-1:0] issue_valid,
  output fe_pkg::fe_op_e       issue_op [`FE_LANES],
  output logic [`FE_LANES-1:0] issue_dst_valid,
  output logic [`FE_TAG_W-1:0] issue_dst_tag [`FE_LANES],
  output logic [`FE_TAG_W-1:0] issue_src1_tag [`FE_LANES],
  output logic [`FE_TAG_W-1:0] issue_src2_tag [`FE_LANES],
  output logic [`FE_IMM_W-1:0] issue_imm [`FE_LANES],
  input  logic                 issue_ready
);
  import fe_pkg::*;

  logic                  start;
  logic [`FE_PC_W:0]     len;
  logic                  busy;
  logic                  done;
  logic                  stall;
  logic                  issued_last;
  logic [`FE_PC_W-1:0]   rd_addr [`FE_LANES];
  logic [31:0]           rd_word [`FE_LANES];
  logic [`FE_LANES-1:0]  fetch_valid;
  logic [31:0]           fetch_word [`FE_LANES];
  logic [`FE_LANES-1:0]  dec_valid;
  logic [`FE_LANES-1:0]  dec_dst_valid;
  fe_op_e                dec_op [`FE_LANES];
  logic [`FE_AREG_W-1:0] dec_rd [`FE_LANES];
  logic [`FE_AREG_W-1:0] dec_rs1 [`FE_LANES];
  logic [`FE_AREG_W-1:0] dec_rs2 [`FE_LANES];
  logic [`FE_IMM_W-1:0]  dec_imm [`FE_LANES];

  fe_apb_regs apb_regs_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .start   (start),
    .len     (len),
    .rd_addr (rd_addr),
    .rd_word (rd_word),
    .busy    (busy),
    .done    (done)
  );

  fe_loader loader_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .len         (len),
    .stall       (stall),
    .issued_last (issued_last),
    .rd_addr     (rd_addr),
    .rd_word     (rd_word),
    .fetch_valid (fetch_valid),
    .fetch_word  (fetch_word),
    .busy        (busy),
    .done        (done)
  );

  // one decoder per lane.
  generate
    for (genvar l = 0; l < `FE_LANES; l++) begin : gen_dec
      fe_decoder decoder_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .stall       (stall),
        .fetch_valid (fetch_valid[l]),
        .fetch_word  (fetch_word[l]),
        .dec_valid   (dec_valid[l]),
        .op          (dec_op[l]),
        .rd          (dec_rd[l]),
        .rs1         (dec_rs1[l]),
        .rs2         (dec_rs2[l]),
        .imm         (dec_imm[l]),
        .dst_valid   (dec_dst_valid[l])
      );
    end
  endgenerate

  fe_renamer renamer_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .dec_valid       (dec_valid),
    .op              (dec_op),
    .rd              (dec_rd),
    .rs1             (dec_rs1),
    .rs2             (dec_rs2),
    .imm             (dec_imm),
    .dst_valid       (dec_dst_valid),
    .stall           (stall),
    .issue_valid     (issue_valid),
    .issue_op        (issue_op),
    .issue_dst_valid (issue_dst_valid),
    .issue_dst_tag   (issue_dst_tag),
    .issue_src1_tag  (issue_src1_tag),
    .issue_src2_tag  (issue_src2_tag),
    .issue_imm       (issue_imm),
    .issued_last     (issued_last),
    .issue_ready     (issue_ready)
  );

endmodule

/* verif/fe_checker.sv */
`timescale 1ns/1ps
`include "fe_settings.svh"

module fe_checker (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 new_prog,
  input  logic [31:0]          prog [`FE_IMEM_DEPTH],
  input  int                   prog_len,
  input  logic [`FE_LANES-1:0] issue_valid,
  input  fe_pkg::fe_op_e       issue_op [`FE_LANES],
  input  logic [`FE_LANES-1:0] issue_dst_valid,
  input  logic [`FE_TAG_W-1:0] issue_dst_tag [`FE_LANES],
  input  logic [`FE_TAG_W-1:0] issue_src1_tag [`FE_LANES],
  input  logic [`FE_TAG_W-1:0] issue_src2_tag [`FE_LANES],
  input  logic [`FE_IMM_W-1:0] issue_imm [`FE_LANES],
  input  logic                 issue_ready,
  output int                   issued,
  output int                   err_count
);
  import fe_pkg::*;

  // reference rename table and tag counter.
  logic [`FE_TAG_W-1:0] ref_table [16];
  logic [`FE_TAG_W-1:0] ref_tag;

  // unknown opcodes behave as nop.
  function automatic logic [3:0] legal_op(input logic [3:0] code);
    case (code)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_LOADI: return code;
      default: return OP_NOP;
    endcase
  endfunction

  task automatic compare(input string name, input int lane, input logic [31:0] exp,
                         input logic [31:0] got);
    if (got !== exp) begin
      $display("FAIL %s[%0d]: expected %h got %h", name, lane, exp, got);
      err_count++;
    end
  endtask

  task automatic check_pair();
    int                    idx;
    logic [`FE_LANES-1:0]  exp_valid;
    logic [`FE_LANES-1:0]  alloc;
    logic [31:0]           word [`FE_LANES];
    logic [3:0]            op [`FE_LANES];
    logic [`FE_AREG_W-1:0] rd [`FE_LANES];
    logic [`FE_AREG_W-1:0] rs1 [`FE_LANES];
    logic [`FE_AREG_W-1:0] rs2 [`FE_LANES];
    logic [`FE_TAG_W-1:0]  dst [`FE_LANES];
    logic [`FE_TAG_W-1:0]  src1 [`FE_LANES];
    logic [`FE_TAG_W-1:0]  src2 [`FE_LANES];
    if (issued >= prog_len) begin
      $display("a pair was issued after the end of the program");
      err_count++;
    end else begin
      for (int l = 0; l < `FE_LANES; l++) begin
        idx = issued + l;
        exp_valid[l] = (idx < prog_len);
        word[l] = exp_valid[l] ? prog[idx[`FE_PC_W-1:0]] : 32'h0;
        op[l] = legal_op(word[l][31:28]);
        rd[l] = word[l][27:24];
        rs1[l] = word[l][23:20];
        rs2[l] = word[l][19:16];
        // only the alu operations read registers.
        if (op[l] == OP_NOP || op[l] == OP_LOADI) begin
          rs1[l] = '0;
          rs2[l] = '0;
        end
        alloc[l] = exp_valid[l] && (op[l] != OP_NOP);
        src1[l] = ref_table[rs1[l]];
        src2[l] = ref_table[rs2[l]];
        // a younger lane sees the fresh destination of an older one.
        for (int k = 0; k < l; k++) begin
          if (alloc[k] && rd[k] == rs1[l]) begin
            src1[l] = dst[k];
          end
          if (alloc[k] && rd[k] == rs2[l]) begin
            src2[l] = dst[k];
          end
        end
        dst[l] = ref_tag;
        if (alloc[l]) begin
          ref_tag = ref_tag + `FE_TAG_W'(1);
        end
      end
      compare("issue_valid", 0, 32'(exp_valid), 32'(issue_valid));
      for (int l = 0; l < `FE_LANES; l++) begin
        if (exp_valid[l]) begin
          compare("issue_op", l, 32'(op[l]), 32'(issue_op[l]));
          compare("issue_dst_valid", l, 32'(alloc[l]), 32'(issue_dst_valid[l]));
          if (alloc[l]) begin
            compare("issue_dst_tag", l, 32'(dst[l]), 32'(issue_dst_tag[l]));
          end
          compare("issue_src1_tag", l, 32'(src1[l]), 32'(issue_src1_tag[l]));
          compare("issue_src2_tag", l, 32'(src2[l]), 32'(issue_src2_tag[l]));
          compare("issue_imm", l, 32'(word[l][15:0]), 32'(issue_imm[l]));
        end
        // the count follows the lanes the DUT marks valid.
        if (issue_valid[l]) begin
          issued = issued + 1;
        end
      end
      // lane 1 writes last, so it wins on a shared rd.
      for (int l = 0; l < `FE_LANES; l++) begin
        if (alloc[l]) begin
          ref_table[rd[l]] = dst[l];
        end
      end
    end
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < 16; r++) begin
        ref_table[r] = `FE_TAG_W'(r);
      end
      ref_tag   = `FE_TAG_W'(16);
      issued    = 0;
      err_count = 0;
    end else if (new_prog) begin
      issued = 0;
    end else if (|issue_valid && issue_ready) begin
      check_pair();
    end
  end

endmodule

/* verif/fe_tb.sv */
`timescale 1ns/1ps
`include "fe_settings.svh"

module fe_tb;
  import fe_pkg::*;

  localparam int prog_timeout = 2000;
  localparam int apb_timeout  = 16;
  localparam int poll_limit   = 20;

  logic                 clk;
  logic                 arst_n;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [11:0]          paddr;
  logic [31:0]          pwdata;
  logic [31:0]          prdata;
  logic                 pready;
  logic                 pslverr;
  logic [`FE_LANES-1:0] issue_valid;
  fe_op_e               issue_op [`FE_LANES];
  logic [`FE_LANES-1:0] issue_dst_valid;
  logic [`FE_TAG_W-1:0] issue_dst_tag [`FE_LANES];
  logic [`FE_TAG_W-1:0] issue_src1_tag [`FE_LANES];
  logic [`FE_TAG_W-1:0] issue_src2_tag [`FE_LANES];
  logic [`FE_IMM_W-1:0] issue_imm [`FE_LANES];
  logic                 issue_ready;

  logic [31:0]          prog [`FE_IMEM_DEPTH];
  int                   prog_len;
  logic                 new_prog;
  int                   issued;
  int                   err_count;
  int                   tb_err;
  int                   err_base;
  int                   tests_run;
  int                   timeouts;
  logic [15:0]          lfsr;

  fe_top fe_top_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .issue_valid     (issue_valid),
    .issue_op        (issue_op),
    .issue_dst_valid (issue_dst_valid),
    .issue_dst_tag   (issue_dst_tag),
    .issue_src1_tag  (issue_src1_tag),
    .issue_src2_tag  (issue_src2_tag),
    .issue_imm       (issue_imm),
    .issue_ready     (issue_ready)
  );

  fe_checker checker_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .new_prog        (new_prog),
    .prog            (prog),
    .prog_len        (prog_len),
    .issue_valid     (issue_valid),
    .issue_op        (issue_op),
    .issue_dst_valid (issue_dst_valid),
    .issue_dst_tag   (issue_dst_tag),
    .issue_src1_tag  (issue_src1_tag),
    .issue_src2_tag  (issue_src2_tag),
    .issue_imm       (issue_imm),
    .issue_ready     (issue_ready),
    .issued          (issued),
    .err_count       (err_count)
  );

  always #50 clk = ~clk;

  // galois form, x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hb400;
    end
    return n;
  endfunction

  task automatic rand_bits(input int count, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < count; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [31:0] encode(input logic [3:0] op, input logic [3:0] rd,
                                         input logic [3:0] rs1, input logic [3:0] rs2,
                                         input logic [15:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  task automatic expect_val(input string name, input logic [31:0] exp,
                            input logic [31:0] got);
    if (got !== exp) begin
      $display("FAIL %s: expected %h got %h", name, exp, got);
      tb_err++;
    end
  endtask

  task automatic apb_access(input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int n;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    for (n = 0; n < apb_timeout; n++) begin
      @(posedge clk);
      if (pready) begin
        break;
      end
    end
    rdata = prdata;
    err   = pslverr;
    if (n == apb_timeout) begin
      $display("APB access to %h never completed", addr);
      timeouts++;
    end else if (n != 0) begin
      // the slave has no wait states.
      $display("APB access to %h took %0d wait states", addr, n);
      tb_err++;
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic err);
    apb_access(1'b0, addr, 32'h0, data, err);
  endtask

  // loads prog[0..n-1], starts the loader and waits for the last issue.
  task automatic run_program(input int n, input logic bp);
    logic [31:0] r;
    logic [31:0] status;
    logic        err;
    int          cyc;
    apb_write(REG_LEN, n, err);
    for (int i = 0; i < n; i++) begin
      apb_write(REG_IMEM_BASE + 12'(4 * i), prog[i], err);
      expect_val("pslverr IMEM write", 32'h0, 32'(err));
    end
    prog_len = n;
    @(negedge clk);
    new_prog = 1'b1;
    @(negedge clk);
    new_prog = 1'b0;
    apb_write(REG_CTRL, 32'h1, err);
    for (cyc = 0; cyc < prog_timeout && issued < n; cyc++) begin
      @(negedge clk);
      if (bp) begin
        rand_bits(1, r);
        issue_ready = r[0];
      end else begin
        issue_ready = 1'b1;
      end
    end
    issue_ready = 1'b1;
    if (issued < n) begin
      $display("program of %0d words issued only %0d before the timeout", n, issued);
      timeouts++;
    end
    status = '0;
    for (cyc = 0; cyc < poll_limit && !status[1]; cyc++) begin
      apb_read(REG_STATUS, status, err);
    end
    if (!status[1]) begin
      $display("done never rose after a program of %0d words", n);
      timeouts++;
    end
    expect_val("issued", n, issued);
  endtask

  task automatic close_test(input string name);
    int now_err;
    now_err = tb_err + err_count + timeouts;
    if (now_err == err_base) begin
      $display("test %0d %s: ok", tests_run + 1, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run + 1, name, now_err - err_base);
    end
    err_base = now_err;
    tests_run++;
  endtask

  initial begin
    logic [31:0] rdata;
    logic [31:0] r;
    logic        err;
    int          n;
    clk         = 1'b0;
    arst_n      = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    issue_ready = 1'b1;
    new_prog    = 1'b0;
    prog_len    = 0;
    tb_err      = 0;
    err_base    = 0;
    tests_run   = 0;
    timeouts    = 0;
    lfsr        = 16'd47575;
    for (int i = 0; i < `FE_IMEM_DEPTH; i++) begin
      prog[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    apb_read(REG_STATUS, rdata, err);
    expect_val("prdata STATUS", 32'h0, rdata);
    expect_val("pslverr STATUS read", 32'h0, 32'(err));
    apb_write(REG_LEN, 32'd37, err);
    apb_read(REG_LEN, rdata, err);
    expect_val("prdata LEN", 32'd37, rdata);
    apb_write(REG_IMEM_BASE, 32'h5a5a_0001, err);
    apb_write(REG_IMEM_BASE + 12'h0fc, 32'hc3c3_003f, err);
    apb_read(REG_IMEM_BASE, rdata, err);
    expect_val("prdata IMEM[0]", 32'h5a5a_0001, rdata);
    apb_read(REG_IMEM_BASE + 12'h0fc, rdata, err);
    expect_val("prdata IMEM[63]", 32'hc3c3_003f, rdata);
    apb_write(REG_STATUS, 32'h3, err);
    expect_val("pslverr STATUS write", 32'h1, 32'(err));
    apb_read(12'h00c, rdata, err);
    expect_val("pslverr unmapped read", 32'h1, 32'(err));
    close_test("register access");

    // first program after reset, tags start right above the identity map.
    prog[0] = encode(OP_ADD, 4'd1, 4'd2, 4'd3, 16'h0);
    prog[1] = encode(OP_ADD, 4'd4, 4'd5, 4'd6, 16'h0);
    run_program(2, 1'b0);
    close_test("fresh renaming");

    prog[0] = encode(OP_ADD, 4'd7, 4'd1, 4'd2, 16'h0);
    prog[1] = encode(OP_SUB, 4'd8, 4'd7, 4'd7, 16'h0);
    prog[2] = encode(OP_LOADI, 4'd3, 4'd0, 4'd0, 16'h00a5);
    prog[3] = encode(OP_OR, 4'd9, 4'd3, 4'd8, 16'h0);
    run_program(4, 1'b0);
    close_test("intra-pair dependency");

    prog[0] = encode(OP_NOP, 4'd1, 4'd2, 4'd3, 16'h1111);
    prog[1] = encode(OP_ADD, 4'd2, 4'd1, 4'd1, 16'h0);
    prog[2] = encode(4'hf, 4'd4, 4'd5, 4'd6, 16'h2222);
    prog[3] = encode(OP_LOADI, 4'd5, 4'd0, 4'd0, 16'hbeef);
    prog[4] = encode(OP_AND, 4'd6, 4'd5, 4'd2, 16'h0);
    run_program(5, 1'b0);
    apb_read(REG_STATUS, rdata, err);
    expect_val("prdata STATUS after program", 32'h2, rdata);
    close_test("odd length and nop");

    for (int p = 0; p < 3; p++) begin
      rand_bits(6, r);
      n = int'(r[5:0]) + 1;
      for (int i = 0; i < n; i++) begin
        // codes 6 and 7 are illegal and exercise the nop path.
        rand_bits(3, r);
        prog[i][31:28] = {1'b0, r[2:0]};
        rand_bits(28, r);
        prog[i][27:0] = r[27:0];
      end
      run_program(n, 1'b1);
    end
    close_test("random programs under back-pressure");

    $display("tests %0d, errors %0d, timeouts %0d", tests_run, tb_err + err_count,
             timeouts);
    if (tb_err + err_count == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+hw
hw/fe_pkg.sv
hw/fe_apb_regs.sv
hw/fe_loader.sv
hw/fe_decoder.sv
hw/fe_renamer.sv
hw/fe_top.sv
verif/fe_checker.sv
verif/fe_tb.sv

/* run.sh */
#!/bin/sh
# build the front end testbench with verilator and run it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --top-module fe_tb -f sources.f -o fe_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/fe_sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TEST PASSED"; then
  exit 0
fi
exit 1
